//--- source/fpm_defs.svh
// fpm shared constants: latency, fp64 field widths and fixed result words
`ifndef FPM_DEFS_SVH
`define FPM_DEFS_SVH

////////////////////////////////////////////////////////////
// timing
////////////////////////////////////////////////////////////

`define FPM_LATENCY 4 // start edge to ready, in clock edges
`define FPM_CNT_W 3

////////////////////////////////////////////////////////////
// fp64 layout and special words
////////////////////////////////////////////////////////////

`define FPM_EXP_W 11
`define FPM_MAN_W 52

`define FPM_CANON_NAN 64'h7ff8_0000_0000_0000 // quiet nan, positive, payload clear
`define FPM_BAD_RESULT 64'h0000_0000_dead_beef // unsupported op or sub-function

`endif

//--- source/fpm_pkg.sv
// fpm package: operand, class, operation code and decoded operand types
`default_nettype none

`include "fpm_defs.svh"

package fpm_pkg;

	// one double precision word, sign + exponent + mantissa
	typedef logic [`FPM_EXP_W+`FPM_MAN_W:0] fp64_t;

	// operation codes, same numbering as the full fpu
	typedef enum logic [4:0]
	{
		OP_SGNJ   = 5'd7,
		OP_CLASS  = 5'd8,
		OP_CMP    = 5'd9,
		OP_MINMAX = 5'd25
	} fpm_op_e;

	// one-hot class, risc-v fclass bit order
	// 0 -inf, 1 -normal, 2 -subnormal, 3 -zero
	// 4 +zero, 5 +subnormal, 6 +normal, 7 +inf
	// 8 signalling nan, 9 quiet nan
	typedef logic [9:0] fpm_class_t;

	// category of one operand, filled in by the decoder
	typedef struct packed
	{
		logic sign;
		logic is_zero;
		logic is_sub;  // exponent zero, mantissa nonzero
		logic is_inf;
		logic is_nan;
		logic is_snan; // subset of is_nan
	} fp_info_t;

endpackage

`default_nettype wire

//--- source/fpm_sequencer.sv
// fpm sequencer: detects the start edge, issues load, latches the op and drives ready
`default_nettype none

module fpm_sequencer
	import fpm_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    enable,
	input  fpm_op_e      fpu_op,
	input  wire logic [2:0] rnd_mode,
	input  wire logic    done,
	output logic         load,
	output logic         ready,
	output fpm_op_e      op_q,
	output logic [2:0]   rnd_q
);

	typedef enum logic [1:0]
	{
		st_idle,
		st_busy,
		st_done
	} seq_state_e;

	seq_state_e state;
	logic       en_q;  // enable as sampled on the previous edge
	logic       start;

	assign start = enable & ~en_q; // rising edge of the level enable

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			en_q  <= 1'b0;
			load  <= 1'b0;
			ready <= 1'b0;
			op_q  <= OP_SGNJ; // sgnj of two zero operands keeps out at zero
			rnd_q <= 3'd0;
		end
		else
		begin
			en_q <= enable;
			load <= 1'b0;

			case (state)
				st_idle, st_done:
					if (start)
					begin
						load  <= 1'b1;
						state <= st_busy;
					end
				st_busy:
					if (done)
					begin
						ready <= 1'b1; // held until the next load
						state <= st_done;
					end
				default: state <= st_idle;
			endcase

			// the edge after the start edge: take the op, drop ready
			if (load)
			begin
				op_q  <= fpu_op;
				rnd_q <= rnd_mode;
				ready <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/fpm_latency_counter.sv
// fpm latency counter: times a running operation and pulses done once at its end
`default_nettype none

`include "fpm_defs.svh"

module fpm_latency_counter
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic load,
	output logic      done
);

	// load takes one edge and ready another, the rest is counted here
	localparam logic [`FPM_CNT_W-1:0] cnt_end = `FPM_CNT_W'(`FPM_LATENCY - 2);

	logic [`FPM_CNT_W-1:0] cnt; // zero means stopped

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt  <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (load)
				cnt <= `FPM_CNT_W'(1);
			else if (cnt != '0)
			begin
				if (cnt == cnt_end)
				begin
					done <= 1'b1;
					cnt  <= '0;
				end
				else
					cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/fpm_operand_decode.sv
// fpm operand decoder: registers one fp64 operand with its ieee category
`default_nettype none

`include "fpm_defs.svh"

module fpm_operand_decode
	import fpm_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic load,
	input  fp64_t     operand,
	output fp64_t     value,
	output fp_info_t  info
);

	logic [`FPM_EXP_W-1:0] exp_f;
	logic [`FPM_MAN_W-1:0] man_f;
	logic                  exp_max;
	logic                  exp_zero;
	logic                  man_zero;
	fp_info_t              info_d;

	assign exp_f    = operand[`FPM_MAN_W +: `FPM_EXP_W];
	assign man_f    = operand[`FPM_MAN_W-1:0];
	assign exp_max  = &exp_f;
	assign exp_zero = ~|exp_f;
	assign man_zero = ~|man_f;

	always_comb
	begin
		info_d.sign    = operand[`FPM_EXP_W+`FPM_MAN_W];
		info_d.is_zero = exp_zero & man_zero;
		info_d.is_sub  = exp_zero & ~man_zero;
		info_d.is_inf  = exp_max & man_zero;
		info_d.is_nan  = exp_max & ~man_zero;
		info_d.is_snan = exp_max & ~man_zero & ~man_f[`FPM_MAN_W-1]; // quiet bit clear
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			value <= '0;
			info  <= '0;
		end
		else if (load)
		begin
			value <= operand;
			info  <= info_d;
		end
	end

endmodule

`default_nettype wire

//--- source/fpm_compare_unit.sv
// fpm compare unit: registered ieee ordering of two decoded operands
`default_nettype none

module fpm_compare_unit
	import fpm_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  fp64_t     a,
	input  fp64_t     b,
	input  fp_info_t  a_info,
	input  fp_info_t  b_info,
	output logic      lt,
	output logic      eq,
	output logic      unordered
)
;

	logic nan_any;
	logic both_zero;
	logic mag_lt;
	logic lt_d;
	logic eq_d;

	assign nan_any   = a_info.is_nan | b_info.is_nan;
	assign both_zero = a_info.is_zero & b_info.is_zero; // +0 == -0
	assign mag_lt    = a[62:0] < b[62:0];

	always_comb
	begin
		eq_d = both_zero | (a == b);
		if (a_info.sign != b_info.sign)
			lt_d = a_info.sign & ~both_zero; // negative below positive
		else if (a_info.sign)
			lt_d = ~mag_lt & (a[62:0] != b[62:0]); // both negative, larger magnitude is less
		else
			lt_d = mag_lt;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lt        <= 1'b0;
			eq        <= 1'b0;
			unordered <= 1'b0;
		end
		else
		begin
			lt        <= lt_d & ~nan_any;
			eq        <= eq_d & ~nan_any;
			unordered <= nan_any;
		end
	end

endmodule

`default_nettype wire

//--- source/fpm_result_select.sv
// fpm result select: registered result word and invalid flag for each operation
`default_nettype none

`include "fpm_defs.svh"

module fpm_result_select
	import fpm_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst,
	input  fpm_op_e         op,
	input  wire logic [2:0] rnd,
	input  fp64_t           a,
	input  fp64_t           b,
	input  fp_info_t        a_info,
	input  fp_info_t        b_info,
	input  wire logic       lt,
	input  wire logic       eq,
	input  wire logic       unordered,
	output fp64_t           out,
	output logic            invalid
);

	// one-hot fclass bit of a decoded operand
	function automatic fpm_class_t classify(input fp_info_t i);
		fpm_class_t c;
		c = '0;
		if (i.is_nan)
			c[i.is_snan ? 8 : 9] = 1'b1;
		else if (i.is_inf)
			c[i.sign ? 0 : 7] = 1'b1;
		else if (i.is_zero)
			c[i.sign ? 3 : 4] = 1'b1;
		else if (i.is_sub)
			c[i.sign ? 2 : 5] = 1'b1;
		else
			c[i.sign ? 1 : 6] = 1'b1;
		return c;
	endfunction

	fp64_t out_d;
	logic  invalid_d;
	logic  a_below;  // a orders below b for min/max
	logic  snan_any;

	assign snan_any = a_info.is_snan | b_info.is_snan;
	assign a_below  = lt | (eq & a_info.sign & ~b_info.sign); // -0 below +0

	always_comb
	begin
		out_d     = `FPM_BAD_RESULT;
		invalid_d = 1'b0;
		case (op)
			////////////////////////////////////////////////////////////
			OP_SGNJ:
				case (rnd)
					3'd0: out_d = {b_info.sign, a[62:0]};
					3'd1: out_d = {a_info.sign ^ b_info.sign, a[62:0]};
					3'd2: out_d = {~b_info.sign, a[62:0]};
					default: out_d = `FPM_BAD_RESULT;
				endcase
			OP_CLASS:
				out_d = fp64_t'(classify(a_info));
			////////////////////////////////////////////////////////////
			OP_CMP:
				case (rnd)
					3'd0:
					begin
						out_d     = fp64_t'((lt | eq) & ~unordered); // le
						invalid_d = unordered;
					end
					3'd1:
					begin
						out_d     = fp64_t'(lt & ~unordered);
						invalid_d = unordered;
					end
					3'd2:
					begin
						out_d     = fp64_t'(eq & ~unordered);
						invalid_d = snan_any; // quiet nan is fine for eq
					end
					default: out_d = `FPM_BAD_RESULT;
				endcase
			OP_MINMAX:
			begin
				invalid_d = snan_any;
				if (a_info.is_nan & b_info.is_nan)
					out_d = `FPM_CANON_NAN;
				else if (a_info.is_nan)
					out_d = b;
				else if (b_info.is_nan)
					out_d = a;
				else if (rnd[0])
					out_d = a_below ? b : a; // max
				else
					out_d = a_below ? a : b; // min
			end
			default: out_d = `FPM_BAD_RESULT;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out     <= '0;
			invalid <= 1'b0;
		end
		else
		begin
			out     <= out_d;
			invalid <= invalid_d;
		end
	end

endmodule

`default_nettype wire

//--- source/fpm_top.sv
// fpm top: misc fp64 operations unit, sequencer and counter around a three stage data path
`default_nettype none

module fpm_top
	import fpm_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       enable,
	input  wire logic [4:0] fpu_op,
	input  wire logic [2:0] rnd_mode,
	input  fp64_t           opa,
	input  fp64_t           opb,
	output fp64_t           out,
	output logic            invalid,
	output logic            ready
);

	fpm_op_e    op_in;
	fpm_op_e    op_q;
	logic [2:0] rnd_q;
	logic       load;
	logic       done;
	fp64_t      a_val;
	fp64_t      b_val;
	fp_info_t   a_info;
	fp_info_t   b_info;
	logic       lt;
	logic       eq;
	logic       unordered;

	assign op_in = fpm_op_e'(fpu_op); // unknown codes pass through to the default result

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	fpm_sequencer u_seq
	(
		.clk      (clk),
		.rst      (rst),
		.enable   (enable),
		.fpu_op   (op_in),
		.rnd_mode (rnd_mode),
		.done     (done),
		.load     (load),
		.ready    (ready),
		.op_q     (op_q),
		.rnd_q    (rnd_q)
	);

	fpm_latency_counter u_cnt
	(
		.clk  (clk),
		.rst  (rst),
		.load (load),
		.done (done)
	);

	////////////////////////////////////////////////////////////
	// data path: decode, compare, result
	////////////////////////////////////////////////////////////

	fpm_operand_decode u_dec_a
	(
		.clk     (clk),
		.rst     (rst),
		.load    (load),
		.operand (opa),
		.value   (a_val),
		.info    (a_info)
	);

	fpm_operand_decode u_dec_b
	(
		.clk     (clk),
		.rst     (rst),
		.load    (load),
		.operand (opb),
		.value   (b_val),
		.info    (b_info)
	);

	fpm_compare_unit u_cmp
	(
		.clk       (clk),
		.rst       (rst),
		.a         (a_val),
		.b         (b_val),
		.a_info    (a_info),
		.b_info    (b_info),
		.lt        (lt),
		.eq        (eq),
		.unordered (unordered)
	);

	fpm_result_select u_res
	(
		.clk       (clk),
		.rst       (rst),
		.op        (op_q),
		.rnd       (rnd_q),
		.a         (a_val),
		.b         (b_val),
		.a_info    (a_info),
		.b_info    (b_info),
		.lt        (lt),
		.eq        (eq),
		.unordered (unordered),
		.out       (out),
		.invalid   (invalid)
	);

endmodule

`default_nettype wire

//--- tests/fpm_chk.sv
// fpm handshake checker: ready latency, load pulse width and result stability
`default_nettype none

`include "fpm_defs.svh"

module fpm_chk
	import fpm_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic enable,
	input wire logic load,
	input wire logic ready,
	input fp64_t     out
);
	timeunit 1ns;
	timeprecision 100ps;

	logic en_q;
	logic start;

	assign start = enable & ~en_q;

	always_ff @(posedge clk)
	begin
		if (rst)
			en_q <= 1'b0;
		else
			en_q <= enable;
	end

	// ready is set on the latency-th edge and first sampled high one edge later
	ready_latency: assert property (@(posedge clk) disable iff (rst)
		$rose(ready) |-> $past(start, `FPM_LATENCY + 1))
		else $error("ready rose without a start edge at the expected latency");

	load_pulse: assert property (@(posedge clk) disable iff (rst) load |=> !load)
		else $error("load stayed high for more than one cycle");

	out_stable: assert property (@(posedge clk) disable iff (rst)
		(ready && $past(ready)) |-> (out == $past(out)))
		else $error("out changed while ready was high");

endmodule

`default_nettype wire

//--- tests/fpm_tb.sv
// fpm testbench driving table and lcg vectors through the misc fp64 unit with handshake checks
`default_nettype none

`include "fpm_defs.svh"

module fpm_clock_gen
(
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
		clk = 1'b0;

	always #4 clk = ~clk; // 8 ns period

endmodule

module fpm_tb
	import fpm_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed
	{
		logic [4:0] op;
		logic [2:0] rnd;
		fp64_t      a;
		fp64_t      b;
		fp64_t      exp_out;
		logic       exp_inv;
	} vec_t;

	logic        clk;
	logic        rst;
	logic        enable;
	logic [4:0]  fpu_op;
	logic [2:0]  rnd_mode;
	fp64_t       opa;
	fp64_t       opb;
	fp64_t       out;
	logic        invalid;
	logic        ready;
	vec_t        vecs[$];
	logic [31:0] seed;
	int          errors;
	int          tests;

	fpm_clock_gen u_clk (.clk(clk));

	fpm_top DUT
	(
		.clk      (clk),
		.rst      (rst),
		.enable   (enable),
		.fpu_op   (fpu_op),
		.rnd_mode (rnd_mode),
		.opa      (opa),
		.opb      (opb),
		.out      (out),
		.invalid  (invalid),
		.ready    (ready)
	);

	bind fpm_top fpm_chk u_chk
	(
		.clk    (clk),
		.rst    (rst),
		.enable (enable),
		.load   (load),
		.ready  (ready),
		.out    (out)
	);

	////////////////////////////////////////////////////////////
	// reference rules and random operands
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// rnd 0 copies b's sign, 1 xors both signs, 2 takes b's sign inverted
	function automatic fp64_t sgnj_model(input logic [2:0] rnd, input fp64_t a, input fp64_t b);
		logic s;
		case (rnd)
			3'd0: s = b[63];
			3'd1: s = a[63] ^ b[63];
			default: s = ~b[63];
		endcase
		return {s, a[62:0]};
	endfunction

	function automatic fp64_t minmax_model(input logic is_max, input fp64_t a, input fp64_t b);
		real ra;
		real rb;
		ra = $bitstoreal(a);
		rb = $bitstoreal(b);
		if (is_max)
			return (rb > ra) ? b : a;
		return (rb < ra) ? b : a;
	endfunction

	task automatic draw(output logic [31:0] r);
		seed = lcg_next(seed);
		r    = seed;
	endtask

	// finite normal operand with exponents kept close so equal exponents are common
	task automatic rand_fp(output fp64_t v);
		logic [31:0] hi;
		logic [31:0] lo;
		draw(hi);
		draw(lo);
		v = {hi[31], 11'd1020 + 11'(hi[2:0]), hi[22:3], lo};
	endtask

	task automatic add_vec(input logic [4:0] op, input logic [2:0] rnd, input fp64_t a,
		input fp64_t b, input fp64_t e, input logic inv);
		vec_t v;
		v.op      = op;
		v.rnd     = rnd;
		v.a       = a;
		v.b       = b;
		v.exp_out = e;
		v.exp_inv = inv;
		vecs.push_back(v);
	endtask

	task automatic add_random(input int count);
		logic [31:0] sel;
		fp64_t       a;
		fp64_t       b;
		logic [2:0]  rnd;
		for (int i = 0; i < count; i++)
		begin
			draw(sel);
			rand_fp(a);
			rand_fp(b);
			if (sel[7])
			begin
				rnd = {2'b00, sel[3]};
				add_vec(5'd25, rnd, a, b, minmax_model(rnd[0], a, b), 1'b0);
			end
			else
			begin
				rnd = 3'(sel[15:8] % 3);
				add_vec(5'd7, rnd, a, b, sgnj_model(rnd, a, b), 1'b0);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// vector table of op, rnd, opa, opb, expected out and expected invalid
	////////////////////////////////////////////////////////////

	task automatic build_table();
		// sign injection
		add_vec(5'd7, 3'd0, 64'h3ff0000000000000, 64'hc000000000000000, 64'hbff0000000000000, 0);
		add_vec(5'd7, 3'd1, 64'hbff0000000000000, 64'hc000000000000000, 64'h3ff0000000000000, 0);
		add_vec(5'd7, 3'd2, 64'h3ff8000000000000, 64'h4000000000000000, 64'hbff8000000000000, 0);
		add_vec(5'd7, 3'd0, 64'h0000000000000000, 64'hfff0000000000000, 64'h8000000000000000, 0);
		add_vec(5'd7, 3'd2, 64'h7ff0000000000001, 64'hbff0000000000000, 64'h7ff0000000000001, 0);
		add_vec(5'd7, 3'd1, 64'hfff8000000000000, 64'h0000000000000000, 64'hfff8000000000000, 0);
		add_vec(5'd7, 3'd3, 64'h3ff0000000000000, 64'h4000000000000000, `FPM_BAD_RESULT, 0);
		// classify once per category
		add_vec(5'd8, 3'd0, 64'hfff0000000000000, 64'h0, 64'h001, 0);
		add_vec(5'd8, 3'd0, 64'hbff0000000000000, 64'h0, 64'h002, 0);
		add_vec(5'd8, 3'd0, 64'h8000000000000001, 64'h0, 64'h004, 0);
		add_vec(5'd8, 3'd0, 64'h8000000000000000, 64'h0, 64'h008, 0);
		add_vec(5'd8, 3'd0, 64'h0000000000000000, 64'h0, 64'h010, 0);
		add_vec(5'd8, 3'd0, 64'h0000000000000001, 64'h0, 64'h020, 0);
		add_vec(5'd8, 3'd0, 64'h3ff0000000000000, 64'h0, 64'h040, 0);
		add_vec(5'd8, 3'd0, 64'h7ff0000000000000, 64'h0, 64'h080, 0);
		add_vec(5'd8, 3'd0, 64'h7ff0000000000001, 64'h0, 64'h100, 0);
		add_vec(5'd8, 3'd0, 64'h7ff8000000000000, 64'h0, 64'h200, 0);
		// compare with rnd 0 le, 1 lt and 2 eq
		add_vec(5'd9, 3'd0, 64'h3ff0000000000000, 64'h4000000000000000, 64'h1, 0);
		add_vec(5'd9, 3'd0, 64'h4000000000000000, 64'h4000000000000000, 64'h1, 0);
		add_vec(5'd9, 3'd0, 64'h4000000000000000, 64'h3ff0000000000000, 64'h0, 0);
		add_vec(5'd9, 3'd1, 64'h3ff0000000000000, 64'h4000000000000000, 64'h1, 0);
		add_vec(5'd9, 3'd1, 64'h4000000000000000, 64'h4000000000000000, 64'h0, 0);
		add_vec(5'd9, 3'd1, 64'hc000000000000000, 64'hbff0000000000000, 64'h1, 0);
		add_vec(5'd9, 3'd2, 64'h4000000000000000, 64'h4000000000000000, 64'h1, 0);
		add_vec(5'd9, 3'd2, 64'h3ff0000000000000, 64'h4000000000000000, 64'h0, 0);
		add_vec(5'd9, 3'd2, 64'h8000000000000000, 64'h0000000000000000, 64'h1, 0);
		add_vec(5'd9, 3'd0, 64'h8000000000000000, 64'h0000000000000000, 64'h1, 0);
		add_vec(5'd9, 3'd1, 64'h8000000000000000, 64'h0000000000000000, 64'h0, 0);
		add_vec(5'd9, 3'd0, 64'h7ff8000000000000, 64'h3ff0000000000000, 64'h0, 1);
		add_vec(5'd9, 3'd1, 64'h3ff0000000000000, 64'h7ff8000000000000, 64'h0, 1);
		add_vec(5'd9, 3'd2, 64'h7ff8000000000000, 64'h3ff0000000000000, 64'h0, 0);
		add_vec(5'd9, 3'd2, 64'h7ff0000000000001, 64'h3ff0000000000000, 64'h0, 1);
		add_vec(5'd9, 3'd3, 64'h3ff0000000000000, 64'h3ff0000000000000, `FPM_BAD_RESULT, 0);
		// min and max where rnd bit 0 picks max
		add_vec(5'd25, 3'd0, 64'h3ff0000000000000, 64'h4000000000000000, 64'h3ff0000000000000, 0);
		add_vec(5'd25, 3'd1, 64'h3ff0000000000000, 64'h4000000000000000, 64'h4000000000000000, 0);
		add_vec(5'd25, 3'd0, 64'hc000000000000000, 64'h3ff0000000000000, 64'hc000000000000000, 0);
		add_vec(5'd25, 3'd1, 64'hc000000000000000, 64'hbff0000000000000, 64'hbff0000000000000, 0);
		add_vec(5'd25, 3'd0, 64'h8000000000000000, 64'h0000000000000000, 64'h8000000000000000, 0);
		add_vec(5'd25, 3'd1, 64'h8000000000000000, 64'h0000000000000000, 64'h0000000000000000, 0);
		add_vec(5'd25, 3'd0, 64'h0000000000000000, 64'h8000000000000000, 64'h8000000000000000, 0);
		add_vec(5'd25, 3'd0, 64'h7ff8000000000000, 64'h4000000000000000, 64'h4000000000000000, 0);
		add_vec(5'd25, 3'd1, 64'h3ff0000000000000, 64'h7ff8000000000000, 64'h3ff0000000000000, 0);
		add_vec(5'd25, 3'd0, 64'h7ff8000000000000, 64'hfff8000000000000, `FPM_CANON_NAN, 0);
		add_vec(5'd25, 3'd1, 64'h7ff0000000000001, 64'h3ff0000000000000, 64'h3ff0000000000000, 1);
		add_vec(5'd25, 3'd0, 64'h7ff0000000000001, 64'h7ff8000000000000, `FPM_CANON_NAN, 1);
		// unsupported operation codes
		add_vec(5'd3, 3'd0, 64'h3ff0000000000000, 64'h4000000000000000, `FPM_BAD_RESULT, 0);
		add_vec(5'd31, 3'd0, 64'h3ff0000000000000, 64'h4000000000000000, `FPM_BAD_RESULT, 0);
		add_random(16);
	endtask

	////////////////////////////////////////////////////////////
	// one operation through the handshake
	////////////////////////////////////////////////////////////

	task automatic run_vec(input vec_t v, input int n, output logic timed_out);
		int   cycles;
		int   err0;
		logic was_low;
		logic seen;
		err0      = errors;
		timed_out = 1'b0;
		fpu_op    = v.op;
		rnd_mode  = v.rnd;
		opa       = v.a;
		opb       = v.b;
		enable    = 1'b1; // start edge is the next rising edge
		cycles    = 0;
		was_low   = 1'b0;
		seen      = 1'b0;
		// ready of the previous operation must fall before the new rise counts
		while (!seen && cycles < 20)
		begin
			@(negedge clk);
			cycles++;
			if (!ready)
				was_low = 1'b1;
			else if (was_low)
				seen = 1'b1;
		end
		if (!seen)
		begin
			$display("test %0d: timeout, ready did not rise within 20 cycles of the start", n);
			errors++;
			timed_out = 1'b1;
			return;
		end
		assert (cycles - 1 == `FPM_LATENCY)
		else
		begin
			$display("test %0d: ready rose %0d cycles after the start edge instead of %0d",
				n, cycles - 1, `FPM_LATENCY);
			errors++;
		end
		assert (out === v.exp_out)
		else
		begin
			$display("ERROR out: got %h expected %h (test %0d)", out, v.exp_out, n);
			errors++;
		end
		assert (invalid === v.exp_inv)
		else
		begin
			$display("ERROR invalid: got %h expected %h (test %0d)", invalid, v.exp_inv, n);
			errors++;
		end
		repeat (2) // enable held high so no second operation may start
		begin
			@(negedge clk);
			assert (ready === 1'b1)
			else
			begin
				$display("ERROR ready: got %h expected %h with enable held high (test %0d)",
					ready, 1'b1, n);
				errors++;
			end
		end
		enable = 1'b0;
		@(negedge clk);
		$display("test %0d op %0d rnd %0d: %s", n, v.op, v.rnd,
			(errors == err0) ? "ok" : "mismatch");
	endtask

	initial
	begin
		logic timed_out;
		enable    = 1'b0;
		fpu_op    = 5'd0;
		rnd_mode  = 3'd0;
		opa       = '0;
		opb       = '0;
		rst       = 1'b1;
		errors    = 0;
		tests     = 0;
		timed_out = 1'b0;
		seed      = 32'd87;
		build_table();
		repeat (3) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		assert (ready === 1'b0)
		else
		begin
			$display("ERROR ready: got %h expected %h after reset", ready, 1'b0);
			errors++;
		end
		assert (out === 64'h0)
		else
		begin
			$display("ERROR out: got %h expected %h after reset", out, 64'h0);
			errors++;
		end
		assert (invalid === 1'b0)
		else
		begin
			$display("ERROR invalid: got %h expected %h after reset", invalid, 1'b0);
			errors++;
		end
		for (int n = 0; n < vecs.size(); n++)
		begin
			run_vec(vecs[n], n, timed_out);
			tests++;
			if (timed_out)
				break;
		end
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0 && !timed_out)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
source/fpm_pkg.sv
source/fpm_sequencer.sv
source/fpm_latency_counter.sv
source/fpm_operand_decode.sv
source/fpm_compare_unit.sv
source/fpm_result_select.sv
source/fpm_top.sv
tests/fpm_chk.sv
tests/fpm_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the fpm testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module fpm_tb -f sim.f -o fpm_sim

output=$(./obj_dir/fpm_sim 2>&1) || true
echo "$output"

if grep -qx "Everything OK" <<< "$output"; then
	exit 0
fi
exit 1
